//--- ivc_pkg.sv
`default_nettype none

package ivc_pkg;

    // router geometry
    localparam int NUM_VC    = 4;
    localparam int NUM_PORTS = 5;
    localparam int DST_W     = NUM_PORTS - 1;  // one-hot over the other ports

    // message classes and weights
    localparam int NUM_CLASS = 2;
    localparam int CLASS_W   = 1;
    localparam int WEIGHT_W  = 4;

    localparam int FPAY_W    = 32;

    typedef logic [NUM_VC-1:0]   vc_mask_t;
    typedef logic [DST_W-1:0]    dst_t;
    typedef logic [CLASS_W-1:0]  class_t;
    typedef logic [WEIGHT_W-1:0] weight_t;

    // allowed output vcs per class, index is the class id
    localparam vc_mask_t [NUM_CLASS-1:0] CLASS_SETTING = {
        4'b1100,  // class 1
        4'b0011   // class 0
    };

    // 38 bit flit as it travels on the link
    typedef struct packed {
        logic                  hdr;
        logic                  tail;
        vc_mask_t              vc;   // one-hot
        logic [FPAY_W-1:0]     payload;
    } flit_t;

    // header view of the payload
    typedef struct packed {
        logic [FPAY_W-CLASS_W-DST_W-WEIGHT_W-1:0] unused;
        class_t                                   class_id;
        dst_t                                     dest_port;
        weight_t                                  weight;
    } hdr_fields_t;

endpackage

`default_nettype wire

//--- fwft_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module fwft_fifo #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 4
) (
    input  wire        clk,
    input  wire        reset,
    input  wire DATA_T din_i,
    input  wire        wr_i,
    input  wire        rd_i,
    output DATA_T      dout_o,
    output logic       empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty_o = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));

    // head always on the output, zero while empty
    assign dout_o = empty_o ? DATA_T'('0) : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_i && !rd_i) begin
                count <= count + 1'b1;
            end else if (!wr_i && rd_i) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        wr_i && !rd_i |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        rd_i |-> !empty_o);

endmodule

`default_nettype wire

//--- header_parser.sv
`timescale 1ns/100ps
`default_nettype none

module header_parser (
    input  wire                  clk,
    input  wire                  reset,
    input  wire ivc_pkg::flit_t  flit_i,
    input  wire                  flit_we_i,
    output ivc_pkg::vc_mask_t    flit_wr_o,
    output ivc_pkg::vc_mask_t    hdr_wr_o,
    output ivc_pkg::hdr_fields_t hdr_o,
    output logic                 tail_o,
    output ivc_pkg::weight_t     weight_o
);

    logic hdr_seen;

    // per-vc write strobes straight from the one-hot vc field
    assign flit_wr_o = flit_we_i ? flit_i.vc : '0;
    assign hdr_seen  = flit_we_i && flit_i.hdr;
    assign hdr_wr_o  = hdr_seen ? flit_i.vc : '0;

    assign hdr_o  = ivc_pkg::hdr_fields_t'(flit_i.payload);  // only meaningful with hdr_wr_o
    assign tail_o = flit_i.tail;

    // input port weight follows the last header
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            weight_o <= ivc_pkg::weight_t'(1);
        end else if (hdr_wr_o != '0) begin
            if (hdr_o.weight == '0) begin
                weight_o <= ivc_pkg::weight_t'(1);  // minimum weight is 1
            end else begin
                weight_o <= hdr_o.weight;
            end
        end
    end

    a_vc_onehot: assert property (@(posedge clk) disable iff (reset)
        flit_we_i |-> $onehot(flit_i.vc));

endmodule

`default_nettype wire

//--- vc_flit_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module vc_flit_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire ivc_pkg::flit_t    flit_i,
    input  wire ivc_pkg::vc_mask_t flit_wr_i,
    input  wire ivc_pkg::vc_mask_t rd_vc_i,
    input  wire                    rd_i,
    output ivc_pkg::flit_t         flit_o,
    output ivc_pkg::vc_mask_t      not_empty_o
);

    localparam int NUM_VC   = ivc_pkg::NUM_VC;
    localparam int MEM_SIZE = NUM_VC * BUF_DEPTH;
    localparam int ADDR_W   = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1;
    localparam int PTR_W    = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W    = $clog2(BUF_DEPTH + 1);
    localparam int VC_W     = (NUM_VC > 1) ? $clog2(NUM_VC) : 1;

    ivc_pkg::flit_t    mem [MEM_SIZE];  // region v holds entries v*BUF_DEPTH ..
    logic [PTR_W-1:0]  wr_ptr [NUM_VC];
    logic [PTR_W-1:0]  rd_ptr [NUM_VC];
    logic [CNT_W-1:0]  count [NUM_VC];
    ivc_pkg::vc_mask_t rd_pop;
    logic [VC_W-1:0]   wr_vc;
    logic [VC_W-1:0]   rd_vc;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // one-hot to binary, or-based so it maps to a plain mux select
    function automatic logic [VC_W-1:0] vc_index(input ivc_pkg::vc_mask_t mask);
        logic [VC_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_VC; i++) begin
            if (mask[i]) begin
                idx = idx | VC_W'(i);
            end
        end
        return idx;
    endfunction

    assign wr_vc   = vc_index(flit_wr_i);
    assign rd_vc   = vc_index(rd_vc_i);
    assign wr_addr = ADDR_W'(wr_vc) * ADDR_W'(BUF_DEPTH) + ADDR_W'(wr_ptr[wr_vc]);
    assign rd_addr = ADDR_W'(rd_vc) * ADDR_W'(BUF_DEPTH) + ADDR_W'(rd_ptr[rd_vc]);
    assign rd_pop  = rd_i ? rd_vc_i : '0;

    always_comb begin
        for (int v = 0; v < NUM_VC; v++) begin
            not_empty_o[v] = (count[v] != '0);
        end
    end

    // head of the selected vc, fall-through
    assign flit_o = not_empty_o[rd_vc] ? mem[rd_addr] : '0;

    // single write port shared by all regions
    always_ff @(posedge clk) begin
        if (flit_wr_i != '0) begin
            mem[wr_addr] <= flit_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < NUM_VC; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < NUM_VC; v++) begin
                if (flit_wr_i[v]) begin
                    wr_ptr[v] <= (wr_ptr[v] == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr[v] + 1'b1;
                end
                if (rd_pop[v]) begin
                    rd_ptr[v] <= (rd_ptr[v] == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr[v] + 1'b1;
                end
                if (flit_wr_i[v] && !rd_pop[v]) begin
                    count[v] <= count[v] + 1'b1;
                end else if (!flit_wr_i[v] && rd_pop[v]) begin
                    count[v] <= count[v] - 1'b1;
                end
            end
        end
    end

    // credits live upstream, so a full vc here means the link misbehaved
    for (genvar v = 0; v < NUM_VC; v++) begin : g_vc_chk
        a_no_write_full: assert property (@(posedge clk) disable iff (reset)
            flit_wr_i[v] && !rd_pop[v] |-> count[v] != CNT_W'(BUF_DEPTH));
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
        rd_i |-> (rd_vc_i & not_empty_o) != '0);

    a_rd_vc_onehot: assert property (@(posedge clk) disable iff (reset)
        rd_i |-> $onehot(rd_vc_i));

endmodule

`default_nettype wire

//--- ivc_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ivc_ctrl #(
    parameter int BUF_DEPTH    = 4,
    parameter int MIN_PCK_SIZE = 2
) (
    input  wire                                           clk,
    input  wire                                           reset,
    input  wire ivc_pkg::vc_mask_t                        flit_wr_i,
    input  wire ivc_pkg::vc_mask_t                        hdr_wr_i,
    input  wire ivc_pkg::hdr_fields_t                     hdr_i,
    input  wire                                           tail_i,
    input  wire ivc_pkg::vc_mask_t                        pop_flit_i,
    input  wire ivc_pkg::vc_mask_t                        pop_pkt_i,
    output ivc_pkg::vc_mask_t                             tail_o,
    output ivc_pkg::dst_t [ivc_pkg::NUM_VC-1:0]           dest_port_o,
    output ivc_pkg::vc_mask_t [ivc_pkg::NUM_VC-1:0]       cand_ovc_o
);

    // most packets a vc can hold at once
    localparam int PCK_CEIL = (BUF_DEPTH + MIN_PCK_SIZE - 1) / MIN_PCK_SIZE;
    localparam int MAX_PCK  = (PCK_CEIL > 0) ? PCK_CEIL : 1;

    ivc_pkg::class_t [ivc_pkg::NUM_VC-1:0] class_head;
    ivc_pkg::vc_mask_t                     class_empty;

    for (genvar v = 0; v < ivc_pkg::NUM_VC; v++) begin : g_vc
        // tail flag per buffered flit, popped on each switch grant
        fwft_fifo #(
            .DATA_T (logic),
            .DEPTH  (BUF_DEPTH)
        ) tail_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (tail_i),
            .wr_i    (flit_wr_i[v]),
            .rd_i    (pop_flit_i[v]),
            .dout_o  (tail_o[v]),
            .empty_o ()
        );

        fwft_fifo #(
            .DATA_T (ivc_pkg::dst_t),
            .DEPTH  (MAX_PCK)
        ) dest_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (hdr_i.dest_port),
            .wr_i    (hdr_wr_i[v]),
            .rd_i    (pop_pkt_i[v]),   // route released
            .dout_o  (dest_port_o[v]),
            .empty_o ()
        );

        fwft_fifo #(
            .DATA_T (ivc_pkg::class_t),
            .DEPTH  (MAX_PCK)
        ) class_fifo (
            .clk     (clk),
            .reset   (reset),
            .din_i   (hdr_i.class_id),
            .wr_i    (hdr_wr_i[v]),
            .rd_i    (pop_pkt_i[v]),
            .dout_o  (class_head[v]),
            .empty_o (class_empty[v])
        );

        // an empty queue reads as class 0 and must give no candidates
        assign cand_ovc_o[v] = class_empty[v] ? '0
                                              : ivc_pkg::CLASS_SETTING[class_head[v]];
    end

endmodule

`default_nettype wire

//--- input_port.sv
`timescale 1ns/100ps
`default_nettype none

module input_port #(
    parameter int BUF_DEPTH    = 4,
    parameter int MIN_PCK_SIZE = 2
) (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire ivc_pkg::flit_t                     flit_i,
    input  wire                                     flit_we_i,
    input  wire                                     sw_grant_i,
    input  wire ivc_pkg::vc_mask_t                  grant_vc_i,
    input  wire ivc_pkg::vc_mask_t                  reset_ivc_i,
    output ivc_pkg::flit_t                          flit_out_o,
    output ivc_pkg::vc_mask_t                       ivc_request_o,
    output ivc_pkg::vc_mask_t                       tail_o,
    output ivc_pkg::weight_t                        weight_o,
    output ivc_pkg::dst_t [ivc_pkg::NUM_VC-1:0]     dest_port_o,
    output ivc_pkg::vc_mask_t [ivc_pkg::NUM_VC-1:0] cand_ovc_o
);

    ivc_pkg::vc_mask_t    flit_wr;
    ivc_pkg::vc_mask_t    hdr_wr;
    ivc_pkg::hdr_fields_t hdr;
    logic                 tail_flag;
    ivc_pkg::vc_mask_t    pop_flit;

    assign pop_flit = sw_grant_i ? grant_vc_i : '0;  // per-vc pop of one flit

    header_parser parser_i (
        .clk       (clk),
        .reset     (reset),
        .flit_i    (flit_i),
        .flit_we_i (flit_we_i),
        .flit_wr_o (flit_wr),
        .hdr_wr_o  (hdr_wr),
        .hdr_o     (hdr),
        .tail_o    (tail_flag),
        .weight_o  (weight_o)
    );

    vc_flit_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) buffer_i (
        .clk         (clk),
        .reset       (reset),
        .flit_i      (flit_i),
        .flit_wr_i   (flit_wr),
        .rd_vc_i     (grant_vc_i),
        .rd_i        (sw_grant_i),
        .flit_o      (flit_out_o),
        .not_empty_o (ivc_request_o)  // a vc requests while it holds flits
    );

    ivc_ctrl #(
        .BUF_DEPTH    (BUF_DEPTH),
        .MIN_PCK_SIZE (MIN_PCK_SIZE)
    ) ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .flit_wr_i   (flit_wr),
        .hdr_wr_i    (hdr_wr),
        .hdr_i       (hdr),
        .tail_i      (tail_flag),
        .pop_flit_i  (pop_flit),
        .pop_pkt_i   (reset_ivc_i),
        .tail_o      (tail_o),
        .dest_port_o (dest_port_o),
        .cand_ovc_o  (cand_ovc_o)
    );

endmodule

`default_nettype wire

//--- input_port_tb.sv
`timescale 1ns/100ps
`default_nettype none

module input_port_tb;

    localparam logic [1:0] OP_IDLE  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_GRANT = 2'd2;
    localparam logic [1:0] OP_REL   = 2'd3;  // route released via reset_ivc_i
    localparam int NV = ivc_pkg::NUM_VC;

    typedef struct packed {
        logic [1:0] op;
        logic [1:0] vc;
        logic       hdr;
        logic       tail;
        logic       zero_w;  // header with weight field forced to 0
    } step_t;

    localparam int N_STEPS = 25;
    localparam step_t STEPS [N_STEPS] = '{
        '{OP_WRITE, 2'd0, 1'b1, 1'b0, 1'b0},  // vc0 packet a head
        '{OP_WRITE, 2'd1, 1'b1, 1'b0, 1'b0},  // vc1 interleaved
        '{OP_WRITE, 2'd0, 1'b0, 1'b1, 1'b0},
        '{OP_WRITE, 2'd1, 1'b0, 1'b1, 1'b0},
        '{OP_WRITE, 2'd0, 1'b1, 1'b0, 1'b1},  // second packet on vc0, zero weight
        '{OP_WRITE, 2'd0, 1'b0, 1'b1, 1'b0},  // vc0 now full
        '{OP_GRANT, 2'd0, 1'b0, 1'b0, 1'b0},
        '{OP_GRANT, 2'd1, 1'b0, 1'b0, 1'b0},
        '{OP_GRANT, 2'd0, 1'b0, 1'b0, 1'b0},
        '{OP_REL,   2'd0, 1'b0, 1'b0, 1'b0},  // vc0 advances to its second packet
        '{OP_GRANT, 2'd1, 1'b0, 1'b0, 1'b0},
        '{OP_REL,   2'd1, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,  2'd2, 1'b0, 1'b0, 1'b0},
        '{OP_WRITE, 2'd3, 1'b1, 1'b1, 1'b0},  // single flit packet
        '{OP_WRITE, 2'd2, 1'b1, 1'b0, 1'b0},
        '{OP_GRANT, 2'd0, 1'b0, 1'b0, 1'b0},
        '{OP_GRANT, 2'd3, 1'b0, 1'b0, 1'b0},
        '{OP_REL,   2'd3, 1'b0, 1'b0, 1'b0},
        '{OP_WRITE, 2'd2, 1'b0, 1'b1, 1'b0},
        '{OP_GRANT, 2'd0, 1'b0, 1'b0, 1'b0},
        '{OP_REL,   2'd0, 1'b0, 1'b0, 1'b0},
        '{OP_GRANT, 2'd2, 1'b0, 1'b0, 1'b0},
        '{OP_GRANT, 2'd2, 1'b0, 1'b0, 1'b0},
        '{OP_REL,   2'd2, 1'b0, 1'b0, 1'b0},
        '{OP_IDLE,  2'd0, 1'b0, 1'b0, 1'b0}
    };

    logic                       clk;
    logic                       reset;
    ivc_pkg::flit_t             flit_in;
    logic                       flit_we;
    logic                       sw_grant;
    ivc_pkg::vc_mask_t          grant_vc;
    ivc_pkg::vc_mask_t          reset_ivc;
    ivc_pkg::flit_t             flit_out;
    ivc_pkg::vc_mask_t          ivc_request;
    ivc_pkg::vc_mask_t          tail;
    ivc_pkg::weight_t           weight;
    ivc_pkg::dst_t [NV-1:0]     dest_port;
    ivc_pkg::vc_mask_t [NV-1:0] cand_ovc;

    // reference model, one flit queue and one packet queue per vc
    ivc_pkg::flit_t       flit_q [NV][$];
    ivc_pkg::hdr_fields_t pkt_q [NV][$];
    ivc_pkg::weight_t     exp_weight;
    ivc_pkg::flit_t       cur_flit [N_STEPS];

    input_port dut_i (
        .clk           (clk),
        .reset         (reset),
        .flit_i        (flit_in),
        .flit_we_i     (flit_we),
        .sw_grant_i    (sw_grant),
        .grant_vc_i    (grant_vc),
        .reset_ivc_i   (reset_ivc),
        .flit_out_o    (flit_out),
        .ivc_request_o (ivc_request),
        .tail_o        (tail),
        .weight_o      (weight),
        .dest_port_o   (dest_port),
        .cand_ovc_o    (cand_ovc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // table length plus a margin for reset and the last check
    initial begin
        #((N_STEPS + 20) * 100);
        $display("watchdog expired before the step table was finished");
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flit(input string name, input ivc_pkg::flit_t got,
                              input ivc_pkg::flit_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input ivc_pkg::vc_mask_t got,
                              input ivc_pkg::vc_mask_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_dst(input string name, input ivc_pkg::dst_t got,
                             input ivc_pkg::dst_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_weight(input string name, input ivc_pkg::weight_t got,
                                input ivc_pkg::weight_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic ivc_pkg::flit_t make_flit(input step_t s);
        ivc_pkg::flit_t       f;
        ivc_pkg::hdr_fields_t h;
        f.hdr     = s.hdr;
        f.tail    = s.tail;
        f.vc      = ivc_pkg::vc_mask_t'(1) << s.vc;
        f.payload = $urandom;
        if (s.hdr && s.zero_w) begin
            h         = ivc_pkg::hdr_fields_t'(f.payload);
            h.weight  = '0;
            f.payload = h;
        end
        return f;
    endfunction

    task automatic drive_step(input step_t s, input ivc_pkg::flit_t f);
        flit_in   <= f;
        flit_we   <= (s.op == OP_WRITE);
        sw_grant  <= (s.op == OP_GRANT);
        grant_vc  <= ivc_pkg::vc_mask_t'(1) << s.vc;  // also selects flit_out_o
        reset_ivc <= (s.op == OP_REL) ? ivc_pkg::vc_mask_t'(1) << s.vc : '0;
    endtask

    task automatic apply_model(input step_t s, input ivc_pkg::flit_t f);
        ivc_pkg::hdr_fields_t h;
        h = ivc_pkg::hdr_fields_t'(f.payload);
        if (s.op == OP_WRITE) begin
            flit_q[s.vc].push_back(f);
            if (s.hdr) begin
                pkt_q[s.vc].push_back(h);
                exp_weight = (h.weight == '0) ? ivc_pkg::weight_t'(1) : h.weight;
            end
        end else if (s.op == OP_GRANT && flit_q[s.vc].size() != 0) begin
            flit_q[s.vc].delete(0);
        end else if (s.op == OP_REL && pkt_q[s.vc].size() != 0) begin
            pkt_q[s.vc].delete(0);
        end else if (s.op != OP_IDLE) begin
            $display("step table pops VC %0d while its queue is empty", s.vc);
            stop_run();
        end
    endtask

    task automatic check_outputs(input logic [1:0] rd_vc);
        ivc_pkg::flit_t             head;
        ivc_pkg::vc_mask_t          exp_req;
        ivc_pkg::vc_mask_t          exp_tail;
        ivc_pkg::dst_t [NV-1:0]     exp_dst;
        ivc_pkg::vc_mask_t [NV-1:0] exp_cand;
        head = '0;
        if (flit_q[rd_vc].size() != 0) begin
            head = flit_q[rd_vc][0];
        end
        for (int v = 0; v < NV; v++) begin
            exp_req[v]  = (flit_q[v].size() != 0);
            exp_tail[v] = exp_req[v] ? flit_q[v][0].tail : 1'b0;
            exp_dst[v]  = '0;
            exp_cand[v] = '0;
            if (pkt_q[v].size() != 0) begin
                exp_dst[v]  = pkt_q[v][0].dest_port;
                // class 0 may use vcs 0 and 1, class 1 vcs 2 and 3
                exp_cand[v] = pkt_q[v][0].class_id ? 4'b1100 : 4'b0011;
            end
        end
        check_flit("flit_out_o", flit_out, head);
        check_mask("ivc_request_o", ivc_request, exp_req);
        check_mask("tail_o", tail, exp_tail);
        check_weight("weight_o", weight, exp_weight);
        for (int v = 0; v < NV; v++) begin
            check_dst($sformatf("dest_port_o[%0d]", v), dest_port[v], exp_dst[v]);
            check_mask($sformatf("cand_ovc_o[%0d]", v), cand_ovc[v], exp_cand[v]);
        end
    endtask

    initial begin
        logic [1:0] rd_vc;
        void'($urandom(32'hd2ec_bcec));
        reset      = 1'b1;
        flit_in    = '0;
        flit_we    = 1'b0;
        sw_grant   = 1'b0;
        grant_vc   = '0;
        reset_ivc  = '0;
        exp_weight = ivc_pkg::weight_t'(1);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // step i is driven at one edge, sampled at the next, checked at the negedge after
        for (int i = 0; i <= N_STEPS; i++) begin
            @(posedge clk);
            if (i > 0) begin
                apply_model(STEPS[i-1], cur_flit[i-1]);
            end
            if (i < N_STEPS) begin
                cur_flit[i] = make_flit(STEPS[i]);
                drive_step(STEPS[i], cur_flit[i]);
                rd_vc = STEPS[i].vc;
            end else begin
                drive_step('0, '0);
                rd_vc = 2'd0;
            end
            @(negedge clk);
            check_outputs(rd_vc);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- input_port.f
ivc_pkg.sv
fwft_fifo.sv
header_parser.sv
vc_flit_buffer.sv
ivc_ctrl.sv
input_port.sv
input_port_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the input port testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f input_port.f \
    --top-module input_port_tb --Mdir obj_dir -o input_port_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/input_port_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
